// ==== build.f ====
+incdir+include
hdl/fetch_pkg.sv
hdl/mem_bus_if.sv
hdl/if_stage.sv
hdl/lsu.sv
hdl/mem_arbiter.sv
hdl/fetch_top.sv
tests/mem_model.sv
tests/fetch_props.sv
tests/fetch_tb.sv

// ==== hdl/fetch_pkg.sv ====
////////////////////
// Bus word views and response codes shared by every requester.
////////////////////
`include "fetch_defines.svh"

package fetch_pkg;

  // One bus word, read whole by the LSU or as two instructions by fetch.
  typedef union packed {
    logic [`FETCH_XLEN-1:0] dword;
    struct packed {
      logic [31:0] hi;   // PC bit 2 set.
      logic [31:0] lo;   // PC bit 2 clear.
    } inst;
  } bus_word_u;

  typedef enum logic [1:0] {
    RESP_OKAY   = `FETCH_RESP_OKAY,
    RESP_SLVERR = `FETCH_RESP_SLVERR
  } bus_resp_e;

endpackage

// ==== hdl/fetch_top.sv ====
////////////////////
// Fetch and LSU share one external memory bus.
////////////////////
`timescale 1ns/1ns
`include "fetch_defines.svh"

module fetch_top (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   i_if_fetched_ack,
  input  logic                   i_if_pc_jmp,
  input  logic [`FETCH_XLEN-1:0] i_if_pc_jmpaddr,
  output logic                   o_if_fetched_req,
  output logic [`FETCH_XLEN-1:0] o_if_pc,
  output logic [`FETCH_XLEN-1:0] o_if_pc_old,
  output logic [`FETCH_XLEN-1:0] o_if_pc_pred,
  output logic [31:0]            o_if_inst,
  output logic                   o_if_fault,
  input  logic                   i_ls_req,
  input  logic                   i_ls_we,
  input  logic [`FETCH_XLEN-1:0] i_ls_addr,
  input  logic [`FETCH_XLEN-1:0] i_ls_wdata,
  output logic                   o_ls_busy,
  output logic                   o_ls_done,
  output logic [`FETCH_XLEN-1:0] o_ls_rdata,
  output logic                   o_ls_err,
  output logic                   o_mem_valid,
  output logic [`FETCH_XLEN-1:0] o_mem_addr,
  output logic                   o_mem_write,
  output logic [`FETCH_XLEN-1:0] o_mem_wdata,
  output logic [1:0]             o_mem_size,
  input  logic                   i_mem_ready,
  input  logic                   i_mem_rvalid,
  input  logic [`FETCH_XLEN-1:0] i_mem_rdata,
  input  logic [1:0]             i_mem_resp
);

  mem_bus_if if_bus ();
  mem_bus_if ls_bus ();

  if_stage u_if_stage (
    .clk              (clk),
    .rst              (rst),
    .bus              (if_bus),
    .i_if_fetched_ack (i_if_fetched_ack),
    .i_if_pc_jmp      (i_if_pc_jmp),
    .i_if_pc_jmpaddr  (i_if_pc_jmpaddr),
    .o_if_fetched_req (o_if_fetched_req),
    .o_if_pc          (o_if_pc),
    .o_if_pc_old      (o_if_pc_old),
    .o_if_pc_pred     (o_if_pc_pred),
    .o_if_inst        (o_if_inst),
    .o_if_fault       (o_if_fault)
  );

  lsu u_lsu (
    .clk        (clk),
    .rst        (rst),
    .bus        (ls_bus),
    .i_ls_req   (i_ls_req),
    .i_ls_we    (i_ls_we),
    .i_ls_addr  (i_ls_addr),
    .i_ls_wdata (i_ls_wdata),
    .o_ls_busy  (o_ls_busy),
    .o_ls_done  (o_ls_done),
    .o_ls_rdata (o_ls_rdata),
    .o_ls_err   (o_ls_err)
  );

  mem_arbiter u_arbiter (
    .clk          (clk),
    .rst          (rst),
    .if_bus       (if_bus),
    .ls_bus       (ls_bus),
    .o_mem_valid  (o_mem_valid),
    .o_mem_addr   (o_mem_addr),
    .o_mem_write  (o_mem_write),
    .o_mem_wdata  (o_mem_wdata),
    .o_mem_size   (o_mem_size),
    .i_mem_ready  (i_mem_ready),
    .i_mem_rvalid (i_mem_rvalid),
    .i_mem_rdata  (i_mem_rdata),
    .i_mem_resp   (i_mem_resp)
  );

endmodule

// ==== hdl/if_stage.sv ====
////////////////////
// Reads one doubleword per instruction; next PC is PC+4 unless a jump came in.
////////////////////
`timescale 1ns/1ns
`include "fetch_defines.svh"

module if_stage (
  input  logic                   clk,
  input  logic                   rst,
  mem_bus_if.requester           bus,
  input  logic                   i_if_fetched_ack,
  input  logic                   i_if_pc_jmp,
  input  logic [`FETCH_XLEN-1:0] i_if_pc_jmpaddr,
  output logic                   o_if_fetched_req,
  output logic [`FETCH_XLEN-1:0] o_if_pc,
  output logic [`FETCH_XLEN-1:0] o_if_pc_old,
  output logic [`FETCH_XLEN-1:0] o_if_pc_pred,
  output logic [31:0]            o_if_inst,
  output logic                   o_if_fault
);

  localparam logic [1:0] S_IDLE = 2'd0;
  localparam logic [1:0] S_REQ  = 2'd1;
  localparam logic [1:0] S_WAIT = 2'd2;
  localparam logic [1:0] S_PRES = 2'd3;

  logic [1:0]             state;
  logic                   jmp_pend;
  logic [`FETCH_XLEN-1:0] jmp_addr_q;
  logic [`FETCH_XLEN-1:0] pc_next;

  assign bus.valid        = (state == S_REQ);
  assign bus.addr         = {o_if_pc[`FETCH_XLEN-1:3], 3'b000};   // Doubleword aligned.
  assign bus.write        = 1'b0;
  assign bus.wdata        = '0;
  assign bus.size         = `FETCH_SIZE_D;
  assign o_if_fetched_req = (state == S_PRES);
  assign o_if_pc_pred     = o_if_pc + `FETCH_XLEN'd4;

  // A jump in the ack cycle itself also counts.
  always_comb begin
    if (i_if_pc_jmp) begin
      pc_next = i_if_pc_jmpaddr;
    end else if (jmp_pend) begin
      pc_next = jmp_addr_q;
    end else begin
      pc_next = o_if_pc_pred;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state       <= S_IDLE;
      jmp_pend    <= 1'b0;
      o_if_pc     <= `FETCH_RESET_PC;
      o_if_pc_old <= `FETCH_RESET_PC;
    end else begin
      if (i_if_pc_jmp) begin
        jmp_pend <= 1'b1;
      end
      case (state)
        S_IDLE: state <= S_REQ;
        S_REQ: begin
          if (bus.ready) begin
            state <= S_WAIT;
          end
        end
        S_WAIT: begin
          if (bus.rvalid) begin
            state <= S_PRES;
          end
        end
        default: begin
          if (i_if_fetched_ack) begin
            state       <= S_REQ;
            jmp_pend    <= 1'b0;   // Consumed by pc_next.
            o_if_pc_old <= o_if_pc;
            o_if_pc     <= pc_next;
          end
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (i_if_pc_jmp) begin
      jmp_addr_q <= i_if_pc_jmpaddr;
    end
    if (state == S_WAIT && bus.rvalid) begin
      o_if_inst  <= o_if_pc[2] ? bus.rdata.inst.hi : bus.rdata.inst.lo;
      o_if_fault <= (bus.resp != fetch_pkg::RESP_OKAY);
    end
  end

endmodule

// ==== hdl/lsu.sv ====
////////////////////
// Strobes while busy are dropped. Stores write the whole doubleword.
////////////////////
`timescale 1ns/1ns
`include "fetch_defines.svh"

module lsu (
  input  logic                   clk,
  input  logic                   rst,
  mem_bus_if.requester           bus,
  input  logic                   i_ls_req,
  input  logic                   i_ls_we,
  input  logic [`FETCH_XLEN-1:0] i_ls_addr,
  input  logic [`FETCH_XLEN-1:0] i_ls_wdata,
  output logic                   o_ls_busy,
  output logic                   o_ls_done,
  output logic [`FETCH_XLEN-1:0] o_ls_rdata,
  output logic                   o_ls_err
);

  logic                   valid_q;
  logic                   we_q;
  logic [`FETCH_XLEN-1:0] addr_q;
  logic [`FETCH_XLEN-1:0] wdata_q;

  assign bus.valid = valid_q;
  assign bus.addr  = addr_q;
  assign bus.write = we_q;
  assign bus.wdata = wdata_q;
  assign bus.size  = `FETCH_SIZE_D;

  always_ff @(posedge clk) begin
    if (rst) begin
      o_ls_busy <= 1'b0;
      o_ls_done <= 1'b0;
      valid_q   <= 1'b0;
    end else begin
      o_ls_done <= 1'b0;
      if (!o_ls_busy) begin
        if (i_ls_req) begin
          o_ls_busy <= 1'b1;
          valid_q   <= 1'b1;
        end
      end else if (valid_q) begin
        if (bus.ready) begin
          valid_q <= 1'b0;   // Accepted, wait for response.
        end
      end else if (bus.rvalid) begin
        o_ls_busy <= 1'b0;
        o_ls_done <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (i_ls_req && !o_ls_busy) begin
      we_q    <= i_ls_we;
      addr_q  <= i_ls_addr;
      wdata_q <= i_ls_wdata;
    end
    if (bus.rvalid) begin
      o_ls_rdata <= bus.rdata.dword;
      o_ls_err   <= (bus.resp != fetch_pkg::RESP_OKAY);
    end
  end

endmodule

// ==== hdl/mem_arbiter.sv ====
////////////////////
// Grant is combinational when idle; bus stays locked until the owner's rvalid.
////////////////////
`timescale 1ns/1ns
`include "fetch_defines.svh"

module mem_arbiter (
  input  logic                   clk,
  input  logic                   rst,
  mem_bus_if.arbiter             if_bus,
  mem_bus_if.arbiter             ls_bus,
  output logic                   o_mem_valid,
  output logic [`FETCH_XLEN-1:0] o_mem_addr,
  output logic                   o_mem_write,
  output logic [`FETCH_XLEN-1:0] o_mem_wdata,
  output logic [1:0]             o_mem_size,
  input  logic                   i_mem_ready,
  input  logic                   i_mem_rvalid,
  input  logic [`FETCH_XLEN-1:0] i_mem_rdata,
  input  logic [1:0]             i_mem_resp
);

  logic locked;
  logic owner_ls;   // Set when the LSU owns the bus.
  logic last_ls;
  logic sel_ls;
  logic grant_if;
  logic grant_ls;

  always_comb begin
    if (locked) begin
      sel_ls = owner_ls;
    end else if (if_bus.valid && ls_bus.valid) begin
      sel_ls = !last_ls;   // Peer not served last wins.
    end else begin
      sel_ls = ls_bus.valid;
    end
  end

  assign grant_ls = sel_ls & (locked | ls_bus.valid);
  assign grant_if = !sel_ls & (locked | if_bus.valid);

  assign o_mem_valid = sel_ls ? ls_bus.valid : if_bus.valid;
  assign o_mem_addr  = sel_ls ? ls_bus.addr  : if_bus.addr;
  assign o_mem_write = sel_ls ? ls_bus.write : if_bus.write;
  assign o_mem_wdata = sel_ls ? ls_bus.wdata : if_bus.wdata;
  assign o_mem_size  = sel_ls ? ls_bus.size  : if_bus.size;

  assign if_bus.ready  = grant_if & i_mem_ready;
  assign ls_bus.ready  = grant_ls & i_mem_ready;
  assign if_bus.rvalid = locked & !owner_ls & i_mem_rvalid;
  assign ls_bus.rvalid = locked & owner_ls & i_mem_rvalid;

  // Data is shared, rvalid tells each peer whether it is meant.
  assign if_bus.rdata = i_mem_rdata;
  assign ls_bus.rdata = i_mem_rdata;
  assign if_bus.resp  = fetch_pkg::bus_resp_e'(i_mem_resp);
  assign ls_bus.resp  = fetch_pkg::bus_resp_e'(i_mem_resp);

  always_ff @(posedge clk) begin
    if (rst) begin
      locked   <= 1'b0;
      owner_ls <= 1'b0;
      last_ls  <= 1'b0;
    end else if (!locked) begin
      if (grant_if || grant_ls) begin
        locked   <= 1'b1;
        owner_ls <= sel_ls;
      end
    end else if (i_mem_rvalid) begin
      locked  <= 1'b0;
      last_ls <= owner_ls;
    end
  end

endmodule

// ==== hdl/mem_bus_if.sv ====
////////////////////
// One requester's memory port; one transaction outstanding at most.
////////////////////
`timescale 1ns/1ns
`include "fetch_defines.svh"

interface mem_bus_if;
  logic                   valid;
  logic                   ready;
  logic [`FETCH_XLEN-1:0] addr;
  logic                   write;
  logic [`FETCH_XLEN-1:0] wdata;
  logic [1:0]             size;
  logic                   rvalid;   // One-cycle response pulse.
  fetch_pkg::bus_word_u   rdata;
  fetch_pkg::bus_resp_e   resp;

  modport requester (
    output valid, addr, write, wdata, size,
    input  ready, rvalid, rdata, resp
  );

  modport arbiter (
    input  valid, addr, write, wdata, size,
    output ready, rvalid, rdata, resp
  );
endinterface

// ==== include/fetch_defines.svh ====
////////////////////
// Sizes are fixed by the 64-bit data path; bus accesses are whole doublewords.
////////////////////
`ifndef FETCH_DEFINES_SVH
`define FETCH_DEFINES_SVH

`define FETCH_RESET_PC   64'h0000_0000_0000_0000
`define FETCH_XLEN       64
`define FETCH_SIZE_D     2'd3

// Response codes, AXI style.
`define FETCH_RESP_OKAY   2'd0
`define FETCH_RESP_SLVERR 2'd2

// 256 doublewords, so addresses from 2048 up answer SLVERR.
`define FETCH_MEM_WORDS  256

`endif

// ==== run.sh ====
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f build.f --top-module fetch_tb -o fetch_sim
./obj_dir/fetch_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "TEST RESULT: FAIL" sim.log; then
  exit 1
fi
if ! grep -q "TEST RESULT: PASS" sim.log; then
  exit 1
fi
exit 0

// ==== tests/fetch_props.sv ====
////////////////////
// Bus and fetched handshake rules, checked at the top level.
////////////////////
`timescale 1ns/1ns
`include "fetch_defines.svh"

module fetch_props (
  input logic                   clk,
  input logic                   rst,
  input logic                   if_valid,
  input logic                   if_ready,
  input logic                   if_rvalid,
  input logic [`FETCH_XLEN-1:0] if_addr,
  input logic                   ls_valid,
  input logic                   ls_ready,
  input logic                   ls_rvalid,
  input logic [`FETCH_XLEN-1:0] ls_addr,
  input logic                   fetched_req,
  input logic                   fetched_ack
);

  logic if_out;   // Fetch read accepted, response pending.
  logic ls_out;   // LSU access accepted, response pending.

  always_ff @(posedge clk) begin
    if (rst) begin
      if_out <= 1'b0;
      ls_out <= 1'b0;
    end else begin
      if (if_valid && if_ready) begin
        if_out <= 1'b1;
      end else if (if_rvalid) begin
        if_out <= 1'b0;
      end
      if (ls_valid && ls_ready) begin
        ls_out <= 1'b1;
      end else if (ls_rvalid) begin
        ls_out <= 1'b0;
      end
    end
  end

  a_if_hold: assert property (@(posedge clk) disable iff (rst)
    if_valid && !if_ready |=> if_valid && $stable(if_addr))
    else $error("fetch request dropped or changed before ready");

  a_ls_hold: assert property (@(posedge clk) disable iff (rst)
    ls_valid && !ls_ready |=> ls_valid && $stable(ls_addr))
    else $error("LSU request dropped or changed before ready");

  a_one_grant: assert property (@(posedge clk) disable iff (rst)
    !(if_out && ls_ready) && !(ls_out && if_ready))
    else $error("both peers granted");

  a_req_hold: assert property (@(posedge clk) disable iff (rst)
    fetched_req && !fetched_ack |=> fetched_req)
    else $error("fetched request fell without ack");

endmodule

bind fetch_top fetch_props u_props (
  .clk         (clk),
  .rst         (rst),
  .if_valid    (if_bus.valid),
  .if_ready    (if_bus.ready),
  .if_rvalid   (if_bus.rvalid),
  .if_addr     (if_bus.addr),
  .ls_valid    (ls_bus.valid),
  .ls_ready    (ls_bus.ready),
  .ls_rvalid   (ls_bus.rvalid),
  .ls_addr     (ls_bus.addr),
  .fetched_req (o_if_fetched_req),
  .fetched_ack (i_if_fetched_ack)
);

// ==== tests/fetch_tb.sv ====
////////////////////
// Memory contents are rebuilt here from the same LCG as the memory model.
////////////////////
`timescale 1ns/1ns
`include "fetch_defines.svh"

module fetch_tb;

  localparam int NSTEPS = 10;

  typedef struct packed {
    logic [7:0]  ack_dly;
    logic        jmp;
    logic [63:0] jaddr;
    logic        ls;
    logic        we;
    logic [63:0] laddr;
    logic [63:0] wdata;
    logic        exp_err;
  } step_t;

  logic        clk;
  logic        rst;
  logic        i_if_fetched_ack;
  logic        i_if_pc_jmp;
  logic [63:0] i_if_pc_jmpaddr;
  logic        o_if_fetched_req;
  logic [63:0] o_if_pc;
  logic [63:0] o_if_pc_old;
  logic [63:0] o_if_pc_pred;
  logic [31:0] o_if_inst;
  logic        o_if_fault;
  logic        i_ls_req;
  logic        i_ls_we;
  logic [63:0] i_ls_addr;
  logic [63:0] i_ls_wdata;
  logic        o_ls_busy;
  logic        o_ls_done;
  logic [63:0] o_ls_rdata;
  logic        o_ls_err;
  logic        mem_valid;
  logic [63:0] mem_addr;
  logic        mem_write;
  logic [63:0] mem_wdata;
  logic [1:0]  mem_size;
  logic        mem_ready;
  logic        mem_rvalid;
  logic [63:0] mem_rdata;
  logic [1:0]  mem_resp;

  step_t       steps [NSTEPS];
  logic [63:0] ref_mem [0:`FETCH_MEM_WORDS-1];
  logic [63:0] pc_exp;
  logic [63:0] old_exp;
  logic [63:0] ls_rdata_q;
  logic        ls_err_q;
  int          errors;
  int          checks;
  int          done_cnt;
  int          accepted;

  fetch_top dut0 (.*,
    .o_mem_valid (mem_valid), .o_mem_addr (mem_addr), .o_mem_write (mem_write),
    .o_mem_wdata (mem_wdata), .o_mem_size (mem_size), .i_mem_ready (mem_ready),
    .i_mem_rvalid (mem_rvalid), .i_mem_rdata (mem_rdata), .i_mem_resp (mem_resp));

  mem_model u_mem (
    .clk (clk), .rst (rst), .i_valid (mem_valid), .i_addr (mem_addr),
    .i_write (mem_write), .i_wdata (mem_wdata), .i_size (mem_size),
    .o_ready (mem_ready), .o_rvalid (mem_rvalid), .o_rdata (mem_rdata),
    .o_resp (mem_resp));

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1103515245 + 32'd12345;
  endfunction

  function automatic step_t make_step(input logic [7:0] dly, input logic jmp,
      input logic [63:0] jaddr, input logic ls, input logic we,
      input logic [63:0] laddr, input logic [63:0] wdata, input logic err);
    return '{dly, jmp, jaddr, ls, we, laddr, wdata, err};
  endfunction

  task automatic build_ref();
    logic [31:0] seed;
    logic [31:0] hi;
    seed = 32'd84;
    for (int i = 0; i < `FETCH_MEM_WORDS; i++) begin
      seed = lcg_next(seed);
      hi   = seed;
      seed = lcg_next(seed);
      ref_mem[i] = {hi, seed} ^ 64'(i);
    end
  endtask

  task automatic load_table();
    steps[0] = make_step(8'd2, 0, 64'h0,    0, 0, 64'h0,   64'h0, 0);
    steps[1] = make_step(8'd3, 0, 64'h0,    1, 1, 64'h400, 64'hdead_beef_0123_4567, 0);
    steps[2] = make_step(8'd2, 1, 64'h404,  1, 0, 64'h400, 64'h0, 0);
    steps[3] = make_step(8'd4, 0, 64'h0,    0, 0, 64'h0,   64'h0, 0);
    steps[4] = make_step(8'd2, 1, 64'h1000, 1, 0, 64'h900, 64'h0, 1);   // Unmapped.
    steps[5] = make_step(8'd2, 1, 64'h10,   0, 0, 64'h0,   64'h0, 0);
    steps[6] = make_step(8'd3, 0, 64'h0,    1, 1, 64'h7f8, 64'h0bad_f00d_cafe_babe, 0);
    steps[7] = make_step(8'd2, 1, 64'h7fc,  1, 0, 64'h7f8, 64'h0, 0);
    steps[8] = make_step(8'd5, 0, 64'h0,    0, 0, 64'h0,   64'h0, 0);
    steps[9] = make_step(8'd2, 0, 64'h0,    0, 0, 64'h0,   64'h0, 0);
  endtask

  task automatic check_value(input string name, input logic [63:0] got,
      input logic [63:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAIL t=%0t %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  // Every wait goes through here so no done pulse is missed.
  task automatic tick();
    @(negedge clk);
    if (o_ls_done) begin
      done_cnt++;
      ls_rdata_q = o_ls_rdata;
      ls_err_q   = o_ls_err;
    end
  endtask

  task automatic run_step(input int n);
    step_t       s;
    logic [63:0] w;
    logic        flt_exp;
    s = steps[n];
    while (!o_if_fetched_req) tick();
    flt_exp = (pc_exp >= 64'd2048);
    w = ref_mem[pc_exp[10:3]];
    check_value("o_if_pc", o_if_pc, pc_exp);
    check_value("o_if_pc_old", o_if_pc_old, old_exp);
    check_value("o_if_pc_pred", o_if_pc_pred, pc_exp + 64'd4);
    check_value("o_if_fault", 64'(o_if_fault), 64'(flt_exp));
    if (!flt_exp) begin
      check_value("o_if_inst", 64'(o_if_inst), pc_exp[2] ? 64'(w[63:32]) : 64'(w[31:0]));
    end
    if (s.ls) begin
      i_ls_req   = 1'b1;
      i_ls_we    = s.we;
      i_ls_addr  = s.laddr;
      i_ls_wdata = s.wdata;
      accepted++;
      if (s.we && s.laddr < 64'd2048) begin
        ref_mem[s.laddr[10:3]] = s.wdata;
      end
    end
    if (s.jmp) begin
      i_if_pc_jmp     = 1'b1;
      i_if_pc_jmpaddr = s.jaddr;
    end
    tick();
    if (s.ls) begin
      check_value("o_ls_busy", 64'(o_ls_busy), 64'd1);
    end
    i_if_pc_jmp = 1'b0;
    i_ls_addr   = 64'h8;   // Second strobe hits a busy LSU.
    tick();
    i_ls_req = 1'b0;
    repeat (s.ack_dly) tick();
    i_if_fetched_ack = 1'b1;
    tick();
    i_if_fetched_ack = 1'b0;
    old_exp = pc_exp;
    pc_exp  = s.jmp ? s.jaddr : pc_exp + 64'd4;
    if (s.ls) begin
      while (done_cnt < accepted) tick();
      check_value("o_ls_busy", 64'(o_ls_busy), 64'd0);
      check_value("o_ls_err", 64'(ls_err_q), 64'(s.exp_err));
      if (!s.we && !s.exp_err) begin
        check_value("o_ls_rdata", ls_rdata_q, ref_mem[s.laddr[10:3]]);
      end
      repeat (3) tick();
      check_value("ls_done_count", 64'(done_cnt), 64'(accepted));
    end
  endtask

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  initial begin
    #(NSTEPS * 40 * 20);
    $display("Timeout: the fetch or LSU handshake never completed");
    $display("TEST RESULT: FAIL");
    $finish;
  end

  initial begin
    rst              = 1'b1;
    i_if_fetched_ack = 1'b0;
    i_if_pc_jmp      = 1'b0;
    i_if_pc_jmpaddr  = 64'h0;
    i_ls_req         = 1'b0;
    i_ls_we          = 1'b0;
    i_ls_addr        = 64'h0;
    i_ls_wdata       = 64'h0;
    errors           = 0;
    checks           = 0;
    done_cnt         = 0;
    accepted         = 0;
    pc_exp           = `FETCH_RESET_PC;
    old_exp          = `FETCH_RESET_PC;
    build_ref();
    load_table();
    repeat (3) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    for (int n = 0; n < NSTEPS; n++) begin
      run_step(n);
    end
    check_value("ls_done_count", 64'(done_cnt), 64'(accepted));
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

// ==== tests/mem_model.sv ====
////////////////////
// One-cycle read latency, random ready stall of 0 to 2 cycles.
// Only 8-byte accesses below 2048 are mapped; the rest answer SLVERR.
////////////////////
`timescale 1ns/1ns
`include "fetch_defines.svh"

module mem_model (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   i_valid,
  input  logic [`FETCH_XLEN-1:0] i_addr,
  input  logic                   i_write,
  input  logic [`FETCH_XLEN-1:0] i_wdata,
  input  logic [1:0]             i_size,
  output logic                   o_ready,
  output logic                   o_rvalid,
  output logic [`FETCH_XLEN-1:0] o_rdata,
  output logic [1:0]             o_resp
);

  logic [`FETCH_XLEN-1:0] mem [0:`FETCH_MEM_WORDS-1];
  logic [31:0]            dly_seed;
  logic [1:0]             wait_cnt;
  logic [7:0]             idx;
  logic                   acc_ok;

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1103515245 + 32'd12345;
  endfunction

  // Stall length from two upper LCG bits, 3 folded to 1.
  function automatic logic [1:0] pick_delay(input logic [31:0] s);
    return (s[17:16] == 2'd3) ? 2'd1 : s[17:16];
  endfunction

  initial begin
    logic [31:0] seed;
    logic [31:0] hi;
    seed = 32'd84;
    for (int i = 0; i < `FETCH_MEM_WORDS; i++) begin
      seed = lcg_next(seed);
      hi   = seed;
      seed = lcg_next(seed);
      mem[i] = {hi, seed} ^ 64'(i);   // Address mixed in.
    end
  end

  assign idx     = i_addr[10:3];
  assign acc_ok  = (i_addr < 64'(`FETCH_MEM_WORDS * 8)) && (i_size == `FETCH_SIZE_D);
  assign o_ready = i_valid && !o_rvalid && (wait_cnt == 2'd0);

  always @(posedge clk) begin
    if (rst) begin
      o_rvalid <= 1'b0;
      wait_cnt <= 2'd0;
      dly_seed <= 32'd84;
    end else begin
      o_rvalid <= 1'b0;
      if (i_valid && o_ready) begin
        o_rvalid <= 1'b1;
        o_resp   <= acc_ok ? `FETCH_RESP_OKAY : `FETCH_RESP_SLVERR;
        o_rdata  <= acc_ok ? mem[idx] : 64'd0;
        if (acc_ok && i_write) begin
          mem[idx] <= i_wdata;
        end
        dly_seed <= lcg_next(dly_seed);
        wait_cnt <= pick_delay(lcg_next(dly_seed));
      end else if (i_valid && wait_cnt != 2'd0) begin
        wait_cnt <= wait_cnt - 2'd1;
      end
    end
  end

endmodule
